// ==== hw/axi_adapter.sv ====
`timescale 1ns/1ps
// AXI subordinate to cpuif bridge; one cpuif request outstanding at a time
// Round-robin between read and write engines, read first after reset
module axi_adapter (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  i3c_csr_pkg::axi_ar_t    ar_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  input  i3c_csr_pkg::axi_ar_t    aw_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  i3c_csr_pkg::axi_w_t     w_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  output i3c_csr_pkg::axi_r_t     r_o,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output i3c_csr_pkg::axi_b_t     b_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  output logic                    cpuif_req_o,
  output i3c_csr_pkg::cpuif_req_t cpuif_req_data_o,
  input  logic                    cpuif_ack_i,
  input  i3c_csr_pkg::cpuif_rsp_t cpuif_rsp_i
);

  logic                    rd_pend;
  logic                    wr_pend;
  i3c_csr_pkg::cpuif_req_t rd_req;
  i3c_csr_pkg::cpuif_req_t wr_req;
  logic                    rd_grant;
  logic                    wr_grant;
  logic                    busy_q;
  logic                    owner_wr_q;
  logic                    prio_wr_q;
  logic                    req_q;
  i3c_csr_pkg::cpuif_req_t req_data_q;

  // Busy from grant until the acknowledge
  assign rd_grant = !busy_q && rd_pend && (!wr_pend || !prio_wr_q);
  assign wr_grant = !busy_q && wr_pend && (!rd_pend || prio_wr_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q     <= 1'b0;
      owner_wr_q <= 1'b0;
      prio_wr_q  <= 1'b0;
      req_q      <= 1'b0;
    end else begin
      req_q <= rd_grant || wr_grant;
      if (rd_grant || wr_grant) begin
        busy_q     <= 1'b1;
        owner_wr_q <= wr_grant;
        prio_wr_q  <= rd_grant;
      end else if (cpuif_ack_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_grant || wr_grant) req_data_q <= wr_grant ? wr_req : rd_req;
  end

  assign cpuif_req_o      = req_q;
  assign cpuif_req_data_o = req_data_q;

  axi_rd_chan u_rd_chan (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ar_i       (ar_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .r_o        (r_o),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .pend_o     (rd_pend),
    .pend_req_o (rd_req),
    .grant_i    (rd_grant),
    .ack_i      (cpuif_ack_i && !owner_wr_q),
    .rsp_i      (cpuif_rsp_i)
  );

  axi_wr_chan u_wr_chan (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .aw_i       (aw_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .w_i        (w_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .b_o        (b_o),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .pend_o     (wr_pend),
    .pend_req_o (wr_req),
    .grant_i    (wr_grant),
    .ack_i      (cpuif_ack_i && owner_wr_q),
    .rsp_i      (cpuif_rsp_i)
  );

endmodule

// ==== hw/axi_rd_chan.sv ====
`timescale 1ns/1ps
// One cpuif read per beat; the next beat is issued only after the R transfer
// WRAP bursts and sizes other than 4 bytes answer SLVERR with no cpuif access
module axi_rd_chan (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  i3c_csr_pkg::axi_ar_t    ar_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  output i3c_csr_pkg::axi_r_t     r_o,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output logic                    pend_o,
  output i3c_csr_pkg::cpuif_req_t pend_req_o,
  input  logic                    grant_i,
  input  logic                    ack_i,
  input  i3c_csr_pkg::cpuif_rsp_t rsp_i
);

  i3c_csr_pkg::chan_state_e           state_q;
  i3c_csr_pkg::axi_ar_t               ar_q;
  logic [7:0]                         beat_q;
  logic                               bad_q;
  logic [i3c_csr_pkg::AXI_DATA_W-1:0] data_q;
  i3c_csr_pkg::axi_resp_e             resp_q;
  logic                               ar_bad;
  logic                               last_beat;

  assign ar_bad = (ar_i.burst != i3c_csr_pkg::FIXED && ar_i.burst != i3c_csr_pkg::INCR) ||
                  (ar_i.size != 3'd2);
  assign last_beat = (beat_q == ar_q.len);

  assign ar_ready_o = (state_q == i3c_csr_pkg::IDLE);
  assign r_valid_o  = (state_q == i3c_csr_pkg::RESP);
  assign pend_o     = (state_q == i3c_csr_pkg::ISSUE);

  always_comb begin
    pend_req_o      = '0;
    pend_req_o.addr = ar_q.addr[i3c_csr_pkg::AXI_ADDR_W-1:2];
  end

  always_comb begin
    r_o.data = data_q;
    r_o.resp = resp_q;
    r_o.id   = ar_q.id;
    r_o.last = last_beat;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= i3c_csr_pkg::IDLE;
    end else begin
      unique case (state_q)
        i3c_csr_pkg::IDLE: begin
          if (ar_valid_i) state_q <= ar_bad ? i3c_csr_pkg::RESP : i3c_csr_pkg::ISSUE;
        end
        i3c_csr_pkg::ISSUE: begin
          if (grant_i) state_q <= i3c_csr_pkg::WAIT_ACK;
        end
        i3c_csr_pkg::WAIT_ACK: begin
          if (ack_i) state_q <= i3c_csr_pkg::RESP;
        end
        default: begin
          // Bad bursts stay here and stream SLVERR beats
          if (r_ready_i && last_beat) begin
            state_q <= i3c_csr_pkg::IDLE;
          end else if (r_ready_i && !bad_q) begin
            state_q <= i3c_csr_pkg::ISSUE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      ar_q   <= ar_i;
      beat_q <= '0;
      bad_q  <= ar_bad;
      data_q <= '0;
      resp_q <= ar_bad ? i3c_csr_pkg::SLVERR : i3c_csr_pkg::OKAY;
    end
    if (state_q == i3c_csr_pkg::WAIT_ACK && ack_i) begin
      data_q <= rsp_i.err ? '0 : rsp_i.rd_data;
      resp_q <= rsp_i.err ? i3c_csr_pkg::SLVERR : i3c_csr_pkg::OKAY;
    end
    if (r_valid_o && r_ready_i && !last_beat) begin
      beat_q <= beat_q + 8'd1;
      if (ar_q.burst == i3c_csr_pkg::INCR) ar_q.addr <= ar_q.addr + 12'd4;
    end
  end

endmodule

// ==== hw/axi_wr_chan.sv ====
`timescale 1ns/1ps
// Accepts one AW, then one W beat per cpuif write; B follows the last acknowledge
// wready depends on the grant, so it is high for one cycle per accepted beat
module axi_wr_chan (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  i3c_csr_pkg::axi_ar_t    aw_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  i3c_csr_pkg::axi_w_t     w_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  output i3c_csr_pkg::axi_b_t     b_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  output logic                    pend_o,
  output i3c_csr_pkg::cpuif_req_t pend_req_o,
  input  logic                    grant_i,
  input  logic                    ack_i,
  input  i3c_csr_pkg::cpuif_rsp_t rsp_i
);

  i3c_csr_pkg::chan_state_e state_q;
  i3c_csr_pkg::axi_ar_t     aw_q;
  logic [7:0]               beat_q;
  logic                     bad_q;
  logic                     err_q;
  logic                     aw_bad;
  logic                     last_beat;
  logic                     w_fire;
  logic                     beat_done;

  function automatic logic [i3c_csr_pkg::AXI_DATA_W-1:0] strb_to_biten(
    input logic [i3c_csr_pkg::STRB_W-1:0] strb
  );
    logic [i3c_csr_pkg::AXI_DATA_W-1:0] biten;
    for (int i = 0; i < i3c_csr_pkg::STRB_W; i++) begin
      biten[8*i +: 8] = {8{strb[i]}};
    end
    return biten;
  endfunction

  assign aw_bad = (aw_i.burst != i3c_csr_pkg::FIXED && aw_i.burst != i3c_csr_pkg::INCR) ||
                  (aw_i.size != 3'd2);
  assign last_beat = (beat_q == aw_q.len);

  assign aw_ready_o = (state_q == i3c_csr_pkg::IDLE);
  assign b_valid_o  = (state_q == i3c_csr_pkg::RESP);
  // Bad bursts drain W without touching the cpuif
  assign pend_o     = (state_q == i3c_csr_pkg::ISSUE) && w_valid_i && !bad_q;
  assign w_ready_o  = (state_q == i3c_csr_pkg::ISSUE) && (bad_q || grant_i);
  assign w_fire     = w_valid_i && w_ready_o;
  assign beat_done  = (w_fire && bad_q) || (state_q == i3c_csr_pkg::WAIT_ACK && ack_i);

  always_comb begin
    pend_req_o.is_wr    = 1'b1;
    pend_req_o.addr     = aw_q.addr[i3c_csr_pkg::AXI_ADDR_W-1:2];
    pend_req_o.wr_data  = w_i.data;
    pend_req_o.wr_biten = strb_to_biten(w_i.strb);
  end

  always_comb begin
    b_o.resp = err_q ? i3c_csr_pkg::SLVERR : i3c_csr_pkg::OKAY;
    b_o.id   = aw_q.id;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= i3c_csr_pkg::IDLE;
    end else begin
      unique case (state_q)
        i3c_csr_pkg::IDLE: begin
          if (aw_valid_i) state_q <= i3c_csr_pkg::ISSUE;
        end
        i3c_csr_pkg::ISSUE: begin
          if (w_fire && !bad_q) begin
            state_q <= i3c_csr_pkg::WAIT_ACK;
          end else if (w_fire && last_beat) begin
            state_q <= i3c_csr_pkg::RESP;
          end
        end
        i3c_csr_pkg::WAIT_ACK: begin
          if (ack_i) state_q <= last_beat ? i3c_csr_pkg::RESP : i3c_csr_pkg::ISSUE;
        end
        default: begin
          if (b_ready_i) state_q <= i3c_csr_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_valid_i && aw_ready_o) begin
      aw_q   <= aw_i;
      beat_q <= '0;
      bad_q  <= aw_bad;
      err_q  <= aw_bad;
    end
    // Sticky over the burst
    if (state_q == i3c_csr_pkg::WAIT_ACK && ack_i && rsp_i.err) begin
      err_q <= 1'b1;
    end
    if (beat_done && !last_beat) begin
      beat_q <= beat_q + 8'd1;
      if (aw_q.burst == i3c_csr_pkg::INCR) aw_q.addr <= aw_q.addr + 12'd4;
    end
  end

endmodule

// ==== hw/i3c_axi_top.sv ====
`timescale 1ns/1ps
// AXI4 access to the I3C register block; INCR and FIXED bursts of 32-bit beats
// No lock or user signals; intr_set_i sets INTR_STATUS bits every cycle
module i3c_axi_top (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  i3c_csr_pkg::axi_ar_t               ar_i,
  input  logic                               ar_valid_i,
  output logic                               ar_ready_o,
  input  i3c_csr_pkg::axi_ar_t               aw_i,
  input  logic                               aw_valid_i,
  output logic                               aw_ready_o,
  input  i3c_csr_pkg::axi_w_t                w_i,
  input  logic                               w_valid_i,
  output logic                               w_ready_o,
  output i3c_csr_pkg::axi_r_t                r_o,
  output logic                               r_valid_o,
  input  logic                               r_ready_i,
  output i3c_csr_pkg::axi_b_t                b_o,
  output logic                               b_valid_o,
  input  logic                               b_ready_i,
  input  logic [7:0]                         intr_set_i,
  output logic [i3c_csr_pkg::AXI_DATA_W-1:0] hc_control_o
);

  logic                    cpuif_req;
  i3c_csr_pkg::cpuif_req_t cpuif_req_data;
  logic                    cpuif_ack;
  i3c_csr_pkg::cpuif_rsp_t cpuif_rsp;

  axi_adapter u_axi_adapter (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .ar_i             (ar_i),
    .ar_valid_i       (ar_valid_i),
    .ar_ready_o       (ar_ready_o),
    .aw_i             (aw_i),
    .aw_valid_i       (aw_valid_i),
    .aw_ready_o       (aw_ready_o),
    .w_i              (w_i),
    .w_valid_i        (w_valid_i),
    .w_ready_o        (w_ready_o),
    .r_o              (r_o),
    .r_valid_o        (r_valid_o),
    .r_ready_i        (r_ready_i),
    .b_o              (b_o),
    .b_valid_o        (b_valid_o),
    .b_ready_i        (b_ready_i),
    .cpuif_req_o      (cpuif_req),
    .cpuif_req_data_o (cpuif_req_data),
    .cpuif_ack_i      (cpuif_ack),
    .cpuif_rsp_i      (cpuif_rsp)
  );

  i3c_csr u_i3c_csr (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (cpuif_req),
    .req_data_i   (cpuif_req_data),
    .ack_o        (cpuif_ack),
    .rsp_o        (cpuif_rsp),
    .intr_set_i   (intr_set_i),
    .hc_control_o (hc_control_o)
  );

endmodule

// ==== hw/i3c_csr.sv ====
`timescale 1ns/1ps
// I3C host controller registers on the cpuif; acknowledge always one cycle later
// Unmapped words answer err with read data 0; HC_VERSION ignores writes
module i3c_csr (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               req_i,
  input  i3c_csr_pkg::cpuif_req_t            req_data_i,
  output logic                               ack_o,
  output i3c_csr_pkg::cpuif_rsp_t            rsp_o,
  input  logic [7:0]                         intr_set_i,
  output logic [i3c_csr_pkg::AXI_DATA_W-1:0] hc_control_o
);

  logic [i3c_csr_pkg::AXI_DATA_W-1:0] hc_control_q;
  logic [i3c_csr_pkg::AXI_DATA_W-1:0] scratch_q;
  logic [7:0]                         intr_status_q;
  logic                               ack_q;
  i3c_csr_pkg::cpuif_rsp_t            rsp_q;
  logic                               sel_ver;
  logic                               sel_ctrl;
  logic                               sel_scr;
  logic                               sel_intr;
  logic                               wr_en;
  logic [i3c_csr_pkg::AXI_DATA_W-1:0] wmask;
  logic [i3c_csr_pkg::AXI_DATA_W-1:0] wdata;
  logic [7:0]                         intr_clr;
  logic [i3c_csr_pkg::AXI_DATA_W-1:0] rd_mux;

  // Word address decode
  assign sel_ver  = req_data_i.addr == i3c_csr_pkg::HC_VERSION_ADDR[11:2];
  assign sel_ctrl = req_data_i.addr == i3c_csr_pkg::HC_CONTROL_ADDR[11:2];
  assign sel_scr  = req_data_i.addr == i3c_csr_pkg::SCRATCH_ADDR[11:2];
  assign sel_intr = req_data_i.addr == i3c_csr_pkg::INTR_STATUS_ADDR[11:2];

  assign wr_en    = req_i && req_data_i.is_wr;
  assign wmask    = req_data_i.wr_biten;
  assign wdata    = req_data_i.wr_data;
  assign intr_clr = (wr_en && sel_intr) ? (wdata[7:0] & wmask[7:0]) : 8'h00;

  always_comb begin
    rd_mux = '0;
    if (sel_ver)  rd_mux = i3c_csr_pkg::HC_VERSION_VAL;
    if (sel_ctrl) rd_mux = hc_control_q;
    if (sel_scr)  rd_mux = scratch_q;
    if (sel_intr) rd_mux = {24'h0, intr_status_q};
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hc_control_q  <= '0;
      scratch_q     <= '0;
      intr_status_q <= '0;
      ack_q         <= 1'b0;
    end else begin
      ack_q <= req_i;
      if (wr_en && sel_ctrl) hc_control_q <= (hc_control_q & ~wmask) | (wdata & wmask);
      if (wr_en && sel_scr) scratch_q <= (scratch_q & ~wmask) | (wdata & wmask);
      // Set beats clear in the same cycle
      intr_status_q <= (intr_status_q & ~intr_clr) | intr_set_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rsp_q.err     <= !(sel_ver || sel_ctrl || sel_scr || sel_intr);
      rsp_q.rd_data <= req_data_i.is_wr ? '0 : rd_mux;
    end
  end

  assign ack_o        = ack_q;
  assign rsp_o        = rsp_q;
  assign hc_control_o = hc_control_q;

endmodule

// ==== hw/i3c_csr_pkg.sv ====
// Shared widths, register map and channel types for the AXI to I3C CSR path
// Beats are always 32 bits, so the cpuif word address is addr[11:2]
package i3c_csr_pkg;

  localparam int unsigned AXI_ADDR_W = 12;
  localparam int unsigned AXI_DATA_W = 32;
  localparam int unsigned AXI_ID_W   = 2;
  localparam int unsigned CSR_ADDR_W = 10;
  localparam int unsigned STRB_W     = AXI_DATA_W / 8;

  // Byte offsets of the register map
  localparam logic [AXI_ADDR_W-1:0] HC_VERSION_ADDR  = 12'h000;
  localparam logic [AXI_ADDR_W-1:0] HC_CONTROL_ADDR  = 12'h004;
  localparam logic [AXI_ADDR_W-1:0] SCRATCH_ADDR     = 12'h008;
  localparam logic [AXI_ADDR_W-1:0] INTR_STATUS_ADDR = 12'h00C;

  localparam logic [AXI_DATA_W-1:0] HC_VERSION_VAL = 32'h0000_0120;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // Shared by the read and write engines
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_ACK,
    RESP
  } chan_state_e;

  // Also used for AW
  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    axi_burst_e            burst;
    logic [2:0]            size;
    logic [7:0]            len;
    logic [AXI_ID_W-1:0]   id;
  } axi_ar_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [STRB_W-1:0]     strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    axi_resp_e             resp;
    logic [AXI_ID_W-1:0]   id;
    logic                  last;
  } axi_r_t;

  typedef struct packed {
    axi_resp_e           resp;
    logic [AXI_ID_W-1:0] id;
  } axi_b_t;

  typedef struct packed {
    logic                  is_wr;
    logic [CSR_ADDR_W-1:0] addr;
    logic [AXI_DATA_W-1:0] wr_data;
    logic [AXI_DATA_W-1:0] wr_biten;
  } cpuif_req_t;

  // Valid together with the acknowledge pulse
  typedef struct packed {
    logic [AXI_DATA_W-1:0] rd_data;
    logic                  err;
  } cpuif_rsp_t;

endpackage

// ==== i3c_axi.f ====
hw/i3c_csr_pkg.sv
hw/axi_rd_chan.sv
hw/axi_wr_chan.sv
hw/axi_adapter.sv
hw/i3c_csr.sv
hw/i3c_axi_top.sv
sim/i3c_axi_sva.sv
sim/tb_i3c_axi.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds tb_i3c_axi with Verilator and runs it; exits non-zero unless the pass line is seen
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f i3c_axi.f --top-module tb_i3c_axi -Mdir obj_dir -o sim_i3c_axi
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_i3c_axi)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
else
  exit 1
fi

// ==== sim/i3c_axi_sva.sv ====
`timescale 1ns/1ps
// Protocol checks bound into axi_adapter
// Assumes the register block acknowledges exactly one cycle after each request
module i3c_axi_sva (
  input logic                clk_i,
  input logic                rst_i,
  input logic                ar_ready_i,
  input logic                aw_ready_i,
  input logic                w_ready_i,
  input i3c_csr_pkg::axi_r_t r_i,
  input logic                r_valid_i,
  input logic                r_ready_i,
  input i3c_csr_pkg::axi_b_t b_i,
  input logic                b_valid_i,
  input logic                b_ready_i,
  input logic                cpuif_req_i,
  input logic                cpuif_ack_i
);

  // Stalled responses keep valid and payload
  r_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else $error("R valid or payload changed while rready was low");

  b_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_i))
    else $error("B valid or payload changed while bready was low");

  ack_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    cpuif_req_i |=> cpuif_ack_i)
    else $error("cpuif acknowledge missing one cycle after the request");

  no_stray_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    cpuif_ack_i |-> $past(cpuif_req_i))
    else $error("cpuif acknowledge without a request in the cycle before");

  // Request cycle, then the acknowledge cycle
  one_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    cpuif_req_i |=> !cpuif_req_i ##1 !cpuif_req_i)
    else $error("new cpuif request while one was outstanding");

  reset_values: assert property (@(posedge clk_i)
    rst_i |=> ar_ready_i && aw_ready_i && !w_ready_i && !r_valid_i && !b_valid_i &&
              !cpuif_req_i)
    else $error("handshake outputs differ from their reset values after reset");

endmodule

bind axi_adapter i3c_axi_sva u_sva (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .ar_ready_i  (ar_ready_o),
  .aw_ready_i  (aw_ready_o),
  .w_ready_i   (w_ready_o),
  .r_i         (r_o),
  .r_valid_i   (r_valid_o),
  .r_ready_i   (r_ready_i),
  .b_i         (b_o),
  .b_valid_i   (b_valid_o),
  .b_ready_i   (b_ready_i),
  .cpuif_req_i (cpuif_req_o),
  .cpuif_ack_i (cpuif_ack_i)
);

// ==== sim/tb_i3c_axi.sv ====
`timescale 1ns/1ps
// AXI traffic against a register model of the I3C CSR block
// Inputs change on the falling edge, outputs are sampled 1 ns later
module tb_i3c_axi;

  logic                    clk;
  logic                    rst;
  i3c_csr_pkg::axi_ar_t    ar;
  logic                    ar_valid;
  logic                    ar_ready;
  i3c_csr_pkg::axi_ar_t    aw;
  logic                    aw_valid;
  logic                    aw_ready;
  i3c_csr_pkg::axi_w_t     w;
  logic                    w_valid;
  logic                    w_ready;
  i3c_csr_pkg::axi_r_t     r;
  logic                    r_valid;
  logic                    r_ready;
  i3c_csr_pkg::axi_b_t     b;
  logic                    b_valid;
  logic                    b_ready;
  logic [7:0]              intr_set;
  logic [31:0]             hc_control;

  // Register model
  logic [31:0]             m_ctrl;
  logic [31:0]             m_scratch;
  logic [7:0]              m_intr;

  // W beats waiting to be sent
  logic [31:0]             wdata_q[$];
  logic [3:0]              wstrb_q[$];

  i3c_axi_top dut (
    .clk_i        (clk),
    .rst_i        (rst),
    .ar_i         (ar),
    .ar_valid_i   (ar_valid),
    .ar_ready_o   (ar_ready),
    .aw_i         (aw),
    .aw_valid_i   (aw_valid),
    .aw_ready_o   (aw_ready),
    .w_i          (w),
    .w_valid_i    (w_valid),
    .w_ready_o    (w_ready),
    .r_o          (r),
    .r_valid_o    (r_valid),
    .r_ready_i    (r_ready),
    .b_o          (b),
    .b_valid_o    (b_valid),
    .b_ready_i    (b_ready),
    .intr_set_i   (intr_set),
    .hc_control_o (hc_control)
  );

  // 100 ns period
  always #50 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
      $display("tests failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic void lookup_reg(input logic [11:0] addr, output logic [31:0] data,
                                     output bit err);
    err  = 1'b0;
    data = '0;
    case (addr)
      i3c_csr_pkg::HC_VERSION_ADDR:  data = 32'h0000_0120;
      i3c_csr_pkg::HC_CONTROL_ADDR:  data = m_ctrl;
      i3c_csr_pkg::SCRATCH_ADDR:     data = m_scratch;
      i3c_csr_pkg::INTR_STATUS_ADDR: data = {24'h0, m_intr};
      default:                       err = 1'b1;
    endcase
  endfunction

  // Byte lanes merge under the strobes; INTR_STATUS clears the ones written
  function automatic void apply_write(input logic [11:0] addr, input logic [31:0] data,
                                      input logic [3:0] strb);
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        case (addr)
          i3c_csr_pkg::HC_CONTROL_ADDR:  m_ctrl[8*i +: 8] = data[8*i +: 8];
          i3c_csr_pkg::SCRATCH_ADDR:     m_scratch[8*i +: 8] = data[8*i +: 8];
          i3c_csr_pkg::INTR_STATUS_ADDR: if (i == 0) m_intr = m_intr & ~data[7:0];
          default: ;
        endcase
      end
    end
  endfunction

  task automatic queue_beats(input int n, input bit full_strb);
    repeat (n) begin
      wdata_q.push_back($urandom);
      wstrb_q.push_back(full_strb ? 4'hF : 4'($urandom_range(15)));
    end
  endtask

  task automatic pulse_intr(input logic [7:0] mask);
    @(negedge clk);
    intr_set = mask;
    m_intr   = m_intr | mask;
    @(negedge clk);
    intr_set = 8'h00;
  endtask

  task automatic read_burst(input logic [11:0] addr, input i3c_csr_pkg::axi_burst_e burst,
                            input logic [2:0] size, input logic [7:0] len,
                            input logic [1:0] id, input bit stall);
    logic [11:0]            beat_addr;
    logic [31:0]            exp_data;
    i3c_csr_pkg::axi_resp_e exp_resp;
    bit                     bad;
    bit                     err;
    int                     beat;
    bad = (burst == i3c_csr_pkg::WRAP) || (size != 3'd2);
    @(negedge clk);
    ar.addr  = addr;
    ar.burst = burst;
    ar.size  = size;
    ar.len   = len;
    ar.id    = id;
    ar_valid = 1'b1;
    #1;
    while (!ar_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    ar_valid = 1'b0;
    beat = 0;
    while (beat <= int'(len)) begin
      r_ready = stall ? ($urandom_range(3) != 0) : 1'b1;
      #1;
      if (r_valid && r_ready) begin
        beat_addr = (burst == i3c_csr_pkg::INCR) ? addr + 12'(4 * beat) : addr;
        lookup_reg(beat_addr, exp_data, err);
        if (bad) begin
          exp_data = '0;
          err      = 1'b1;
        end
        exp_resp = err ? i3c_csr_pkg::SLVERR : i3c_csr_pkg::OKAY;
        check_value("r_o.data", exp_data, r.data);
        check_value("r_o.resp", 32'(exp_resp), 32'(r.resp));
        check_value("r_o.id", 32'(id), 32'(r.id));
        check_value("r_o.last", 32'(beat == int'(len)), 32'(r.last));
        beat++;
      end
      @(negedge clk);
    end
    r_ready = 1'b0;
  endtask

  // Beats come from wdata_q and wstrb_q
  task automatic write_burst(input logic [11:0] addr, input i3c_csr_pkg::axi_burst_e burst,
                             input logic [2:0] size, input logic [7:0] len,
                             input logic [1:0] id, input bit stall);
    logic [11:0]            beat_addr;
    logic [31:0]            data;
    logic [3:0]             strb;
    logic [31:0]            old_data;
    i3c_csr_pkg::axi_resp_e exp_resp;
    bit                     bad;
    bit                     err;
    bit                     any_err;
    bit                     done;
    bad     = (burst == i3c_csr_pkg::WRAP) || (size != 3'd2);
    any_err = bad;
    @(negedge clk);
    aw.addr  = addr;
    aw.burst = burst;
    aw.size  = size;
    aw.len   = len;
    aw.id    = id;
    aw_valid = 1'b1;
    #1;
    while (!aw_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    aw_valid = 1'b0;
    for (int beat = 0; beat <= int'(len); beat++) begin
      data    = wdata_q.pop_front();
      strb    = wstrb_q.pop_front();
      w.data  = data;
      w.strb  = strb;
      w.last  = (beat == int'(len));
      w_valid = 1'b1;
      #1;
      while (!w_ready) begin
        @(negedge clk);
        #1;
      end
      beat_addr = (burst == i3c_csr_pkg::INCR) ? addr + 12'(4 * beat) : addr;
      if (!bad) begin
        lookup_reg(beat_addr, old_data, err);
        any_err = any_err || err;
        apply_write(beat_addr, data, strb);
      end
      @(negedge clk);
    end
    w_valid  = 1'b0;
    exp_resp = any_err ? i3c_csr_pkg::SLVERR : i3c_csr_pkg::OKAY;
    done     = 1'b0;
    while (!done) begin
      b_ready = stall ? ($urandom_range(3) != 0) : 1'b1;
      #1;
      if (b_valid && b_ready) begin
        check_value("b_o.resp", 32'(exp_resp), 32'(b.resp));
        check_value("b_o.id", 32'(id), 32'(b.id));
        done = 1'b1;
      end
      @(negedge clk);
    end
    b_ready = 1'b0;
    check_value("hc_control_o", m_ctrl, hc_control);
  endtask

  initial begin
    // Well above the longest run, including random stalls
    repeat (2000) @(posedge clk);
    $display("Watchdog expired: tests did not finish within 2000 clock cycles");
    $display("tests failed");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(31));
    clk       = 1'b0;
    rst       = 1'b1;
    ar        = '0;
    ar_valid  = 1'b0;
    aw        = '0;
    aw_valid  = 1'b0;
    w         = '0;
    w_valid   = 1'b0;
    r_ready   = 1'b0;
    b_ready   = 1'b0;
    intr_set  = 8'h00;
    m_ctrl    = '0;
    m_scratch = '0;
    m_intr    = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Reset values
    read_burst(i3c_csr_pkg::HC_VERSION_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'd0, 1'b0);
    read_burst(i3c_csr_pkg::HC_CONTROL_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'd1, 1'b0);
    read_burst(i3c_csr_pkg::SCRATCH_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'd2, 1'b0);
    read_burst(i3c_csr_pkg::INTR_STATUS_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'd3, 1'b0);

    // Strobed single writes
    for (int i = 0; i < 4; i++) begin
      queue_beats(1, 1'b0);
      write_burst(i3c_csr_pkg::SCRATCH_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'(i), 1'b0);
      read_burst(i3c_csr_pkg::SCRATCH_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'(i), 1'b0);
      queue_beats(1, 1'b0);
      write_burst(i3c_csr_pkg::HC_CONTROL_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'(i), 1'b0);
      read_burst(i3c_csr_pkg::HC_CONTROL_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'(i), 1'b0);
    end
    queue_beats(1, 1'b1);
    write_burst(i3c_csr_pkg::HC_VERSION_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'd1, 1'b0);
    read_burst(i3c_csr_pkg::HC_VERSION_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'd1, 1'b0);

    // Bursts over the whole map
    queue_beats(4, 1'b1);
    write_burst(i3c_csr_pkg::HC_VERSION_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd3, 2'd2, 1'b0);
    read_burst(i3c_csr_pkg::HC_VERSION_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd3, 2'd1, 1'b0);
    read_burst(i3c_csr_pkg::SCRATCH_ADDR, i3c_csr_pkg::FIXED, 3'd2, 8'd2, 2'd3, 1'b0);

    // Errors leave every register alone
    read_burst(12'h010, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'd0, 1'b0);
    read_burst(i3c_csr_pkg::HC_CONTROL_ADDR, i3c_csr_pkg::WRAP, 3'd2, 8'd1, 2'd1, 1'b0);
    read_burst(i3c_csr_pkg::SCRATCH_ADDR, i3c_csr_pkg::INCR, 3'd1, 8'd1, 2'd2, 1'b0);
    queue_beats(1, 1'b1);
    write_burst(12'h040, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'd3, 1'b0);
    queue_beats(2, 1'b1);
    write_burst(i3c_csr_pkg::HC_CONTROL_ADDR, i3c_csr_pkg::WRAP, 3'd2, 8'd1, 2'd0, 1'b0);
    queue_beats(2, 1'b1);
    write_burst(i3c_csr_pkg::SCRATCH_ADDR, i3c_csr_pkg::INCR, 3'd1, 8'd1, 2'd1, 1'b0);
    read_burst(i3c_csr_pkg::HC_VERSION_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd3, 2'd2, 1'b0);

    // Interrupt set and write-one-to-clear
    pulse_intr(8'hA5);
    read_burst(i3c_csr_pkg::INTR_STATUS_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'd0, 1'b0);
    wdata_q.push_back(32'h0000_0021);
    wstrb_q.push_back(4'hF);
    write_burst(i3c_csr_pkg::INTR_STATUS_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'd1, 1'b0);
    // Byte 0 disabled, so nothing clears
    wdata_q.push_back(32'h0000_00FF);
    wstrb_q.push_back(4'b1110);
    write_burst(i3c_csr_pkg::INTR_STATUS_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'd2, 1'b0);
    read_burst(i3c_csr_pkg::INTR_STATUS_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'd3, 1'b0);
    pulse_intr(8'h18);
    read_burst(i3c_csr_pkg::INTR_STATUS_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'd0, 1'b0);

    // Overlapping traffic with random rready and bready stalls
    queue_beats(12, 1'b0);
    fork
      begin
        for (int k = 0; k < 4; k++) begin
          write_burst(i3c_csr_pkg::SCRATCH_ADDR, i3c_csr_pkg::FIXED, 3'd2, 8'd2, 2'(k), 1'b1);
        end
      end
      begin
        for (int k = 0; k < 4; k++) begin
          read_burst(i3c_csr_pkg::HC_VERSION_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd1,
                     2'(k + 1), 1'b1);
        end
      end
    join
    read_burst(i3c_csr_pkg::SCRATCH_ADDR, i3c_csr_pkg::INCR, 3'd2, 8'd0, 2'd0, 1'b0);

    $display("all tests passed");
    $finish;
  end

endmodule
